//--- verilog/xadc_pkg.sv
package xadc_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and limits
    ////////////////////////////////////////////////////////////

    localparam int sample_bits = 12;
    localparam int word_bits = 64;
    localparam int num_vmms = 8;         // Front-end chips on the monitor mux
    localparam int slots_per_word = 5;   // 5 x 12 bits below the header
    localparam int max_words_per_frame = 150;
    localparam int header_lsb = 60;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] vmm_id_t;       // 1..8 picks one chip, else all
    typedef logic [2:0] vmm_idx_t;       // Zero based, also the header
    typedef logic [4:0] adc_channel_t;
    typedef logic [sample_bits-1:0] adc_sample_t;
    typedef logic [10:0] sample_count_t;
    typedef logic [17:0] delay_t;        // Idle cycles between samples
    typedef logic [word_bits-1:0] fifo_word_t;
    typedef logic [11:0] packet_len_t;
    typedef logic [2:0] slot_idx_t;

    ////////////////////////////////////////////////////////////
    // State machines
    ////////////////////////////////////////////////////////////

    // Command level sequencing
    typedef enum logic [2:0] {
        seq_idle,
        seq_request,
        seq_wait_result,
        seq_delay,
        seq_wait_flush,
        seq_wait_release
    } seq_state_t;

    // One conversion on the ADC port
    typedef enum logic [1:0] {
        rd_idle,
        rd_start,
        rd_wait_done
    } reader_state_t;

endpackage

//--- verilog/xadc_sequencer.sv
`timescale 1ns/1ns

module xadc_sequencer
(
    input  logic                    clk200,
    input  logic                    rst,
    input  logic                    data_in_rdy,
    input  xadc_pkg::vmm_id_t       vmm_id,
    input  xadc_pkg::sample_count_t sample_size,
    input  xadc_pkg::delay_t        delay_in,
    input  logic                    udp_done,
    input  logic                    result_valid,
    input  logic                    last_written,
    output logic                    conv_req,
    output xadc_pkg::vmm_idx_t      conv_vmm,
    output logic                    conv_last,
    output logic                    xadc_busy
);

    xadc_pkg::seq_state_t    state;
    xadc_pkg::sample_count_t size_r;     // Latched command
    xadc_pkg::delay_t        delay_r;
    logic                    all_mode_r;
    xadc_pkg::vmm_idx_t      chip_idx;
    xadc_pkg::sample_count_t req_cnt;    // Requests issued for this chip
    xadc_pkg::delay_t        delay_cnt;
    logic                    all_mode;
    logic                    chip_done;
    logic                    issue_now;

    // Zero or anything past the last chip reads them all
    assign all_mode = (vmm_id == '0) || (vmm_id > xadc_pkg::vmm_id_t'(xadc_pkg::num_vmms));
    assign chip_done = (req_cnt == size_r);

    // A request goes out on entry, right after a result with no delay,
    // or when the delay count runs out
    always_comb
    begin
        issue_now = 1'b0;
        case (state)
            xadc_pkg::seq_request:
                issue_now = 1'b1;
            xadc_pkg::seq_wait_result:
                issue_now = result_valid && !chip_done && (delay_r == '0);
            xadc_pkg::seq_delay:
                issue_now = (delay_cnt == delay_r);
            default:
                issue_now = 1'b0;
        endcase
    end

    assign conv_vmm = chip_idx;

    ////////////////////////////////////////////////////////////
    // Main sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state <= xadc_pkg::seq_idle;
            conv_req <= 1'b0;
            conv_last <= 1'b0;
            xadc_busy <= 1'b0;
        end
        else
        begin
            conv_req <= issue_now;
            if (issue_now)
            begin
                req_cnt <= req_cnt + 1'b1;
                conv_last <= (xadc_pkg::sample_count_t'(req_cnt + 1'b1) == size_r);
            end

            case (state)
                xadc_pkg::seq_idle:
                begin
                    if (data_in_rdy)
                    begin
                        size_r <= sample_size;
                        delay_r <= delay_in;
                        all_mode_r <= all_mode;
                        // Chips count from 1 on the command side
                        chip_idx <= all_mode ? '0 : xadc_pkg::vmm_idx_t'(vmm_id - 1'b1);
                        req_cnt <= '0;
                        xadc_busy <= 1'b1;
                        state <= xadc_pkg::seq_request;
                    end
                end

                xadc_pkg::seq_request:
                    state <= xadc_pkg::seq_wait_result;

                xadc_pkg::seq_wait_result:
                begin
                    if (result_valid)
                    begin
                        if (chip_done)
                            state <= xadc_pkg::seq_wait_flush;
                        else if (delay_r != '0)
                        begin
                            delay_cnt <= xadc_pkg::delay_t'(1);
                            state <= xadc_pkg::seq_delay;
                        end
                    end
                end

                xadc_pkg::seq_delay:
                begin
                    if (delay_cnt == delay_r)
                        state <= xadc_pkg::seq_wait_result;
                    else
                        delay_cnt <= delay_cnt + 1'b1;
                end

                xadc_pkg::seq_wait_flush:
                begin
                    if (last_written)
                    begin
                        if (all_mode_r && chip_idx != xadc_pkg::vmm_idx_t'(xadc_pkg::num_vmms - 1))
                        begin
                            chip_idx <= chip_idx + 1'b1;   // Next chip
                            req_cnt <= '0;
                            state <= xadc_pkg::seq_request;
                        end
                        else
                            state <= xadc_pkg::seq_wait_release;
                    end
                end

                xadc_pkg::seq_wait_release:
                begin
                    // Old command withdrawn and frame sent
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state <= xadc_pkg::seq_idle;
                    end
                end

                default:
                    state <= xadc_pkg::seq_idle;
            endcase
        end
    end

    // Only one conversion in flight through the reader
    a_one_outstanding: assert property (@(posedge clk200) disable iff (rst)
        result_valid |-> state == xadc_pkg::seq_wait_result);

endmodule

//--- verilog/adc_channel_reader.sv
`timescale 1ns/1ns

module adc_channel_reader
(
    input  logic                   clk200,
    input  logic                   rst,
    input  logic                   conv_req,
    input  xadc_pkg::vmm_idx_t     conv_vmm,
    input  logic                   conv_last,
    input  logic                   adc_done,
    input  xadc_pkg::adc_sample_t  adc_result,
    output logic                   adc_start,
    output xadc_pkg::adc_channel_t adc_channel,
    output logic                   result_valid,
    output xadc_pkg::adc_sample_t  result,
    output xadc_pkg::vmm_idx_t     result_vmm,
    output logic                   result_last
);

    xadc_pkg::reader_state_t state;

    assign adc_start = (state == xadc_pkg::rd_start);   // One cycle wide

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state <= xadc_pkg::rd_idle;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= 1'b0;
            case (state)
                xadc_pkg::rd_idle:
                    if (conv_req)
                        state <= xadc_pkg::rd_start;
                xadc_pkg::rd_start:
                    state <= xadc_pkg::rd_wait_done;
                xadc_pkg::rd_wait_done:
                begin
                    if (adc_done)
                    begin
                        result_valid <= 1'b1;
                        state <= xadc_pkg::rd_idle;
                    end
                end
                default:
                    state <= xadc_pkg::rd_idle;
            endcase
        end
    end

    // Channel and tags held for the whole conversion
    always_ff @(posedge clk200)
    begin
        if (state == xadc_pkg::rd_idle && conv_req)
        begin
            adc_channel <= xadc_pkg::adc_channel_t'(conv_vmm);   // Monitor input per chip
            result_vmm <= conv_vmm;
            result_last <= conv_last;
        end
        if (state == xadc_pkg::rd_wait_done && adc_done)
            result <= adc_result;
    end

    // ADC must only answer a start it was given
    a_done_in_wait: assert property (@(posedge clk200) disable iff (rst)
        adc_done |-> state == xadc_pkg::rd_wait_done);

endmodule

//--- verilog/sample_packer.sv
`timescale 1ns/1ns

module sample_packer
(
    input  logic                  clk200,
    input  logic                  rst,
    input  logic                  result_valid,
    input  xadc_pkg::adc_sample_t result,
    input  xadc_pkg::vmm_idx_t    result_vmm,
    input  logic                  result_last,
    output logic                  word_valid,
    output xadc_pkg::fifo_word_t  word,
    output logic                  word_last
);

    xadc_pkg::fifo_word_t acc;    // Word being filled
    xadc_pkg::fifo_word_t filled;
    xadc_pkg::slot_idx_t  slot;
    logic                 word_full;

    assign word_full = (slot == xadc_pkg::slot_idx_t'(xadc_pkg::slots_per_word - 1));

    ////////////////////////////////////////////////////////////
    // Word with the incoming sample merged in
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        filled = acc;
        for (int k = 0; k < xadc_pkg::slots_per_word; k++)
        begin
            if (slot == xadc_pkg::slot_idx_t'(k))
                filled[k*xadc_pkg::sample_bits +: xadc_pkg::sample_bits] = result;
        end
        // Header is a zero then the chip index
        filled[xadc_pkg::header_lsb +: 4] = {1'b0, result_vmm};
    end

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            acc <= '0;
            slot <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= 1'b0;
            if (result_valid)
            begin
                if (word_full || result_last)
                begin
                    word_valid <= 1'b1;
                    acc <= '0;        // Unused slots stay zero next time
                    slot <= '0;
                end
                else
                begin
                    acc <= filled;
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // Output word and end flag
    always_ff @(posedge clk200)
    begin
        if (result_valid && (word_full || result_last))
        begin
            word <= filled;
            word_last <= result_last;
        end
    end

    // A partly filled word belongs to one chip
    a_one_chip_per_word: assert property (@(posedge clk200) disable iff (rst)
        (result_valid && slot != '0) |-> result_vmm == acc[xadc_pkg::header_lsb +: 3]);

endmodule

//--- verilog/word_writer.sv
`timescale 1ns/1ns

module word_writer
(
    input  logic                  clk200,
    input  logic                  rst,
    input  logic                  word_valid,
    input  xadc_pkg::fifo_word_t  word,
    input  logic                  word_last,
    output xadc_pkg::fifo_word_t  fifo_bus,
    output logic                  data_fifo_enable,
    output xadc_pkg::packet_len_t packet_len,
    output logic                  end_of_data,
    output logic                  last_written
);

    xadc_pkg::packet_len_t frame_cnt;   // Words already in this frame
    xadc_pkg::packet_len_t next_cnt;
    logic                  frame_end;

    assign next_cnt = frame_cnt + 1'b1;

    // Close the frame on the last chip word or at the UDP limit
    assign frame_end = word_last ||
        (next_cnt == xadc_pkg::packet_len_t'(xadc_pkg::max_words_per_frame));

    ////////////////////////////////////////////////////////////
    // FIFO write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            frame_cnt <= '0;
            packet_len <= '0;
            data_fifo_enable <= 1'b0;
            end_of_data <= 1'b0;
            last_written <= 1'b0;
        end
        else
        begin
            data_fifo_enable <= word_valid;
            end_of_data <= word_valid && frame_end;   // Single cycle marker
            last_written <= word_valid && word_last;
            if (word_valid)
            begin
                packet_len <= next_cnt;   // Starts at 1
                if (frame_end)
                    frame_cnt <= '0;
                else
                    frame_cnt <= next_cnt;
            end
        end
    end

    // Data bus follows the accepted word
    always_ff @(posedge clk200)
    begin
        if (word_valid)
            fifo_bus <= word;
    end

    // Words are spaced by at least one conversion
    a_no_back_to_back: assert property (@(posedge clk200) disable iff (rst)
        data_fifo_enable |=> !data_fifo_enable);

endmodule

//--- verilog/xadc_readout.sv
`timescale 1ns/1ns

module xadc_readout
(
    input  logic                    clk200,
    input  logic                    rst,
    input  logic                    data_in_rdy,
    input  xadc_pkg::vmm_id_t       vmm_id,
    input  xadc_pkg::sample_count_t sample_size,
    input  xadc_pkg::delay_t        delay_in,
    input  logic                    udp_done,
    input  logic                    adc_done,
    input  xadc_pkg::adc_sample_t   adc_result,
    output logic                    adc_start,
    output xadc_pkg::adc_channel_t  adc_channel,
    output xadc_pkg::fifo_word_t    fifo_bus,
    output logic                    data_fifo_enable,
    output xadc_pkg::packet_len_t   packet_len,
    output logic                    end_of_data,
    output logic                    xadc_busy
);

    logic                  conv_req;
    xadc_pkg::vmm_idx_t    conv_vmm;
    logic                  conv_last;
    logic                  result_valid;
    xadc_pkg::adc_sample_t result;
    xadc_pkg::vmm_idx_t    result_vmm;
    logic                  result_last;
    logic                  word_valid;
    xadc_pkg::fifo_word_t  word;
    logic                  word_last;
    logic                  last_written;

    ////////////////////////////////////////////////////////////
    // Sequencer, reader, packer, writer
    ////////////////////////////////////////////////////////////

    xadc_sequencer xadc_sequencer_i
    (
        .clk200       (clk200),
        .rst          (rst),
        .data_in_rdy  (data_in_rdy),
        .vmm_id       (vmm_id),
        .sample_size  (sample_size),
        .delay_in     (delay_in),
        .udp_done     (udp_done),
        .result_valid (result_valid),
        .last_written (last_written),
        .conv_req     (conv_req),
        .conv_vmm     (conv_vmm),
        .conv_last    (conv_last),
        .xadc_busy    (xadc_busy)
    );

    adc_channel_reader adc_channel_reader_i
    (
        .clk200       (clk200),
        .rst          (rst),
        .conv_req     (conv_req),
        .conv_vmm     (conv_vmm),
        .conv_last    (conv_last),
        .adc_done     (adc_done),
        .adc_result   (adc_result),
        .adc_start    (adc_start),
        .adc_channel  (adc_channel),
        .result_valid (result_valid),
        .result       (result),
        .result_vmm   (result_vmm),
        .result_last  (result_last)
    );

    sample_packer sample_packer_i
    (
        .clk200       (clk200),
        .rst          (rst),
        .result_valid (result_valid),
        .result       (result),
        .result_vmm   (result_vmm),
        .result_last  (result_last),
        .word_valid   (word_valid),
        .word         (word),
        .word_last    (word_last)
    );

    word_writer word_writer_i
    (
        .clk200           (clk200),
        .rst              (rst),
        .word_valid       (word_valid),
        .word             (word),
        .word_last        (word_last),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .last_written     (last_written)
    );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
    output logic clk200,
    output logic rst
);

    initial
    begin
        clk200 = 1'b0;
        forever #20 clk200 = ~clk200;   // 40 ns period
    end

    // Reset held over the first 8 rising edges
    initial
    begin
        rst = 1'b1;
        repeat (8) @(posedge clk200);
        rst <= 1'b0;
    end

endmodule

//--- dv/xadc_readout_tb.sv
`timescale 1ns/1ns

module xadc_readout_tb;

    logic                    clk200;
    logic                    rst;
    logic                    data_in_rdy;
    xadc_pkg::vmm_id_t       vmm_id;
    xadc_pkg::sample_count_t sample_size;
    xadc_pkg::delay_t        delay_in;
    logic                    udp_done;
    logic                    adc_done;
    xadc_pkg::adc_sample_t   adc_result;
    logic                    adc_start;
    xadc_pkg::adc_channel_t  adc_channel;
    xadc_pkg::fifo_word_t    fifo_bus;
    logic                    data_fifo_enable;
    xadc_pkg::packet_len_t   packet_len;
    logic                    end_of_data;
    logic                    xadc_busy;

    logic [31:0]            lcg_state = 32'h4fd4_aff8;
    int                     cycle = 0;
    xadc_pkg::adc_sample_t  sample_q[$];    // Values returned by the ADC model
    xadc_pkg::adc_channel_t chan_q[$];
    int                     start_cyc_q[$];
    int                     done_cyc_q[$];
    xadc_pkg::fifo_word_t   word_q[$];      // Words seen on the FIFO bus
    xadc_pkg::packet_len_t  len_q[$];
    logic                   eod_q[$];

    tb_clock tb_clock_i
    (
        .clk200 (clk200),
        .rst    (rst)
    );

    xadc_readout xadc_readout_i
    (
        .clk200           (clk200),
        .rst              (rst),
        .data_in_rdy      (data_in_rdy),
        .vmm_id           (vmm_id),
        .sample_size      (sample_size),
        .delay_in         (delay_in),
        .udp_done         (udp_done),
        .adc_done         (adc_done),
        .adc_result       (adc_result),
        .adc_start        (adc_start),
        .adc_channel      (adc_channel),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .xadc_busy        (xadc_busy)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch at %0t ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        abort_run();
    endtask

    function automatic int word_timeout(input int samples, input int delay);
        return samples * (delay + 16) + 200;   // Worst case per conversion plus margin
    endfunction

    task automatic wait_busy(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (xadc_busy !== level && n < limit)
        begin
            @(posedge clk200);
            n++;
        end
        if (xadc_busy !== level)
            report_timeout(what);
    endtask

    task automatic wait_words(input int count, input int limit);
        int n;
        n = 0;
        while (word_q.size() < count && n < limit)
        begin
            @(negedge clk200);   // Monitor has pushed by now
            n++;
        end
        if (word_q.size() < count)
            report_timeout("the expected number of FIFO words");
    endtask

    task automatic clear_records();
        sample_q.delete();
        chan_q.delete();
        start_cyc_q.delete();
        done_cyc_q.delete();
        word_q.delete();
        len_q.delete();
        eod_q.delete();
    endtask

    task automatic start_command(input int id, input int size, input int delay);
        clear_records();
        @(posedge clk200);
        vmm_id <= xadc_pkg::vmm_id_t'(id);
        sample_size <= xadc_pkg::sample_count_t'(size);
        delay_in <= xadc_pkg::delay_t'(delay);
        data_in_rdy <= 1'b1;
        udp_done <= 1'b0;
        wait_busy(1'b1, 10, "xadc_busy to rise after the command");
    endtask

    task automatic release_command();
        @(posedge clk200);
        data_in_rdy <= 1'b0;
        udp_done <= 1'b1;
        wait_busy(1'b0, 10, "xadc_busy to fall after release");
        udp_done <= 1'b0;
    endtask

    task automatic expect_busy_for(input int cycles, input string why);
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge clk200);
            compare_value(why, 64'(1), 64'(xadc_busy));
        end
    endtask

    // Rebuilds the expected words from the recorded ADC values
    task automatic verify_readout(input int first_chip, input int chips, input int size,
                                  input int delay);
        int                   words_per_chip;
        int                   w;
        int                   fcnt;
        int                   len;
        int                   s;
        logic                 eod;
        xadc_pkg::fifo_word_t exp;
        words_per_chip = (size + 4) / 5;
        compare_value("sample count", 64'(chips * size), 64'(sample_q.size()));
        compare_value("word count", 64'(chips * words_per_chip), 64'(word_q.size()));
        for (int i = 0; i < chips * size; i++)
        begin
            compare_value("adc_channel", 64'(first_chip + i / size), 64'(chan_q[i]));
            if (i % size != 0)   // Spacing inside one chip only
                compare_value("adc_start spacing", 64'(delay + 3),
                              64'(start_cyc_q[i] - done_cyc_q[i - 1]));
        end
        w = 0;
        fcnt = 0;
        for (int c = 0; c < chips; c++)
        begin
            for (int k = 0; k < words_per_chip; k++)
            begin
                exp = '0;
                exp[63:60] = {1'b0, 3'(first_chip + c)};
                for (int j = 0; j < 5; j++)
                begin
                    s = k * 5 + j;
                    if (s < size)
                        exp[j * 12 +: 12] = sample_q[c * size + s];
                end
                len = fcnt + 1;
                eod = (k == words_per_chip - 1) || (len == 150);
                fcnt = eod ? 0 : len;
                compare_value("fifo_bus", exp, word_q[w]);
                compare_value("packet_len", 64'(len), 64'(len_q[w]));
                compare_value("end_of_data", 64'(eod), 64'(eod_q[w]));
                w++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // ADC model, FIFO monitor and cycle count
    ////////////////////////////////////////////////////////////

    always @(posedge clk200)
        cycle <= cycle + 1;

    initial
    begin : adc_model
        int          wait_cycles;
        logic [31:0] r;
        adc_done = 1'b0;
        adc_result = '0;
        forever
        begin
            @(posedge clk200);
            if (adc_start === 1'b1)
            begin
                start_cyc_q.push_back(cycle);
                chan_q.push_back(adc_channel);
                r = lcg_next();
                wait_cycles = 1 + int'(r[18:16]);   // 1 to 8 cycles
                repeat (wait_cycles) @(posedge clk200);
                r = lcg_next();
                adc_result <= r[27:16];
                adc_done <= 1'b1;
                sample_q.push_back(r[27:16]);
                @(posedge clk200);
                done_cyc_q.push_back(cycle);
                adc_done <= 1'b0;
            end
        end
    end

    always @(posedge clk200)
    begin
        if (!rst && data_fifo_enable)
        begin
            word_q.push_back(fifo_bus);
            len_q.push_back(packet_len);
            eod_q.push_back(end_of_data);
        end
        if (!rst && end_of_data && !data_fifo_enable)
        begin
            $display("end_of_data was high without data_fifo_enable at %0t ns", $time);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        int n;
        n = 0;
        while (rst && n < 20)
        begin
            @(posedge clk200);
            n++;
        end
        if (rst)
            report_timeout("reset to end");
        @(posedge clk200);
        compare_value("xadc_busy", 64'(0), 64'(xadc_busy));
        compare_value("adc_start", 64'(0), 64'(adc_start));
        compare_value("data_fifo_enable", 64'(0), 64'(data_fifo_enable));
        compare_value("end_of_data", 64'(0), 64'(end_of_data));
        compare_value("packet_len", 64'(0), 64'(packet_len));
    endtask

    task automatic read_single_chip();
        start_command(3, 7, 4);
        wait_words(2, word_timeout(7, 4));
        release_command();
        verify_readout(2, 1, 7, 4);   // Chip 3 is index 2
    endtask

    task automatic read_all_chips();
        start_command(0, 5, 2);
        wait_words(8, word_timeout(40, 2));
        release_command();
        verify_readout(0, 8, 5, 2);
    endtask

    task automatic run_frame_limit();
        start_command(1, 760, 0);
        wait_words(152, word_timeout(760, 0));
        release_command();
        verify_readout(0, 1, 760, 0);
    endtask

    task automatic hold_busy_release();
        start_command(6, 4, 20);
        wait_words(1, word_timeout(4, 20));
        expect_busy_for(10, "xadc_busy with udp_done low");
        udp_done <= 1'b1;
        expect_busy_for(10, "xadc_busy with data_in_rdy high");
        data_in_rdy <= 1'b0;
        wait_busy(1'b0, 5, "xadc_busy to fall once both are released");
        udp_done <= 1'b0;
        for (int i = 0; i < 20; i++)
        begin
            @(posedge clk200);
            compare_value("adc_start", 64'(0), 64'(adc_start));
            compare_value("xadc_busy", 64'(0), 64'(xadc_busy));
        end
        verify_readout(5, 1, 4, 20);
    endtask

    initial
    begin
        data_in_rdy = 1'b0;
        vmm_id = '0;
        sample_size = '0;
        delay_in = '0;
        udp_done = 1'b0;
        reset_state();
        read_single_chip();
        read_all_chips();
        run_frame_limit();
        hold_busy_release();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- sim.f
verilog/xadc_pkg.sv
verilog/xadc_sequencer.sv
verilog/adc_channel_reader.sv
verilog/sample_packer.sv
verilog/word_writer.sv
verilog/xadc_readout.sv
dv/tb_clock.sv
dv/xadc_readout_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = xadc_readout_tb
FLIST = sim.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
